// ==== rtl/dcache_params.svh ====
// data cache geometry and field widths
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ------------------------------
// address and data widths
// ------------------------------
`define DC_ADDR_W   30  // word address
`define DC_WORD_W   32
`define DC_LINE_W   128 // four words per line

// ------------------------------
// geometry
// ------------------------------
`define DC_TAG_W    26
`define DC_INDEX_W  2
`define DC_OFFSET_W 2   // word within line
`define DC_SETS     4
`define DC_WAYS     2

`endif

// ==== rtl/dcache_pkg.sv ====
// data cache shared types and controller state encoding
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

	// ------------------------------
	// data and address fields
	// ------------------------------
	typedef logic [`DC_WORD_W-1:0] word_t;
	typedef logic [`DC_LINE_W-1:0] line_t;
	typedef logic [`DC_TAG_W-1:0] tag_t;
	typedef logic [`DC_INDEX_W-1:0] index_t;
	typedef logic [`DC_TAG_W+`DC_INDEX_W-1:0] line_addr_t; // tag then index

	// one entry of a tag array
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	// miss handling states
	typedef enum logic [1:0] {
		st_compare    = 2'b00,
		st_write_back = 2'b01,
		st_allocate   = 2'b10
	} dc_state_t;

endpackage

`default_nettype wire

// ==== rtl/dcache_way_array.sv ====
// storage for one way of the cache, one entry per set, read combinationally
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_way_array #(
	parameter type entry_t = dcache_pkg::line_t
) (
	input wire clk,
	input wire proc_reset,

	// read side, addressed set
	input wire dcache_pkg::index_t rd_index,
	output entry_t rd_entry,

	// write side, from the controller
	input wire wr_en,
	input wire dcache_pkg::index_t wr_index,
	input wire entry_t wr_entry
);

	entry_t entries [`DC_SETS]; // one entry per set

	// ------------------------------
	// write port
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int i = 0; i < `DC_SETS; i++) begin
				entries[i] <= '0; // valid bits drop with the rest
			end
		end else if (wr_en) begin
			entries[wr_index] <= wr_entry;
		end
	end

	// read is same-cycle
	assign rd_entry = entries[rd_index];

endmodule

`default_nettype wire

// ==== rtl/dcache_lookup.sv ====
// tag compare, hit word select, write merge and victim extraction for one set
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_lookup (
	input wire logic [`DC_ADDR_W-1:0] proc_addr,
	input wire dcache_pkg::word_t proc_wdata,

	// addressed set, both ways
	input wire dcache_pkg::tag_entry_t tag0,
	input wire dcache_pkg::tag_entry_t tag1,
	input wire dcache_pkg::line_t line0,
	input wire dcache_pkg::line_t line1,
	input wire victim_way,

	output logic hit0,
	output logic hit1,
	output dcache_pkg::word_t rdata,
	output dcache_pkg::line_t merged_line,
	output logic victim_dirty,
	output dcache_pkg::line_addr_t victim_addr,
	output dcache_pkg::line_t victim_line
);

	dcache_pkg::tag_t addr_tag;
	dcache_pkg::index_t addr_index;
	logic [`DC_OFFSET_W-1:0] addr_offset;
	dcache_pkg::line_t hit_line;
	dcache_pkg::tag_entry_t victim_entry;

	// ------------------------------
	// address split
	// ------------------------------
	assign addr_tag    = proc_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign addr_index  = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign addr_offset = proc_addr[`DC_OFFSET_W-1:0];

	// hit per way, only on valid entries
	assign hit0 = tag0.valid && (tag0.tag == addr_tag);
	assign hit1 = tag1.valid && (tag1.tag == addr_tag);

	assign hit_line = hit1 ? line1 : line0;
	assign rdata    = hit_line[addr_offset*`DC_WORD_W +: `DC_WORD_W];

	// store data lands at the word offset, rest of line kept
	always_comb begin
		merged_line = hit_line;
		merged_line[addr_offset*`DC_WORD_W +: `DC_WORD_W] = proc_wdata;
	end

	// ------------------------------
	// victim side
	// ------------------------------
	assign victim_entry = victim_way ? tag1 : tag0;
	assign victim_dirty = victim_entry.valid && victim_entry.dirty;
	assign victim_addr  = {victim_entry.tag, addr_index}; // line lives at its own tag
	assign victim_line  = victim_way ? line1 : line0;

endmodule

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
// miss handling FSM with fill-order replacement, array writes and memory port
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl (
	input wire clk,
	input wire proc_reset,

	// processor request
	input wire proc_read,
	input wire proc_write,
	input wire logic [`DC_ADDR_W-1:0] proc_addr,
	output logic proc_stall,

	// from the lookup
	input wire hit0,
	input wire hit1,
	input wire victim_dirty,
	input wire dcache_pkg::line_addr_t victim_addr,
	input wire dcache_pkg::line_t victim_line,
	input wire dcache_pkg::line_t merged_line,
	input wire dcache_pkg::tag_entry_t tag0,
	input wire dcache_pkg::tag_entry_t tag1,
	output logic victim_way,

	// way array writes
	output logic [`DC_WAYS-1:0] tag_wr_en,
	output logic [`DC_WAYS-1:0] data_wr_en,
	output dcache_pkg::tag_entry_t wr_tag_entry,
	output dcache_pkg::line_t wr_line,

	// memory port
	output logic mem_read,
	output logic mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	output dcache_pkg::line_t mem_wdata,
	input wire dcache_pkg::line_t mem_rdata,
	input wire mem_ready
);

	dcache_pkg::dc_state_t state;
	dcache_pkg::dc_state_t state_nxt;
	logic [`DC_SETS-1:0] mrf; // way most recently filled, per set
	dcache_pkg::tag_t addr_tag;
	dcache_pkg::index_t addr_index;
	dcache_pkg::tag_entry_t victim_entry;
	logic miss;

	assign addr_tag   = proc_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign addr_index = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];

	// victim is the way not filled last
	assign victim_way   = ~mrf[addr_index];
	assign victim_entry = victim_way ? tag1 : tag0;

	assign miss = (proc_read || proc_write) && !hit0 && !hit1;

	// ------------------------------
	// next state and outputs
	// ------------------------------
	always_comb begin
		state_nxt    = state;
		proc_stall   = 1'b0;
		tag_wr_en    = '0;
		data_wr_en   = '0;
		wr_tag_entry = '{valid: 1'b1, dirty: 1'b1, tag: addr_tag};
		wr_line      = merged_line;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_addr     = {addr_tag, addr_index}; // fill address
		mem_wdata    = victim_line;

		case (state)
			dcache_pkg::st_compare: begin
				proc_stall = miss;
				if (miss) begin
					state_nxt = victim_dirty ? dcache_pkg::st_write_back
						: dcache_pkg::st_allocate;
				end else if (proc_write) begin
					// write hit, merge word and mark dirty
					tag_wr_en[hit1]  = 1'b1;
					data_wr_en[hit1] = 1'b1;
				end
			end

			dcache_pkg::st_write_back: begin
				proc_stall = 1'b1;
				mem_write  = 1'b1;
				mem_addr   = victim_addr;
				if (mem_ready) begin
					// line is clean in memory now
					wr_tag_entry           = victim_entry;
					wr_tag_entry.dirty     = 1'b0;
					tag_wr_en[victim_way]  = 1'b1;
					state_nxt              = dcache_pkg::st_allocate;
				end
			end

			dcache_pkg::st_allocate: begin
				proc_stall = 1'b1;
				mem_read   = 1'b1;
				wr_line    = mem_rdata;
				if (mem_ready) begin
					wr_tag_entry           = '{valid: 1'b1, dirty: 1'b0, tag: addr_tag};
					tag_wr_en[victim_way]  = 1'b1;
					data_wr_en[victim_way] = 1'b1;
					state_nxt              = dcache_pkg::st_compare; // request hits next
				end
			end

			default: state_nxt = dcache_pkg::st_compare;
		endcase
	end

	// ------------------------------
	// state and replacement bits
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= dcache_pkg::st_compare;
			mrf   <= '0;
		end else begin
			state <= state_nxt;
			// only fills move the replacement bit, hits leave it
			if (state == dcache_pkg::st_allocate && mem_ready) begin
				mrf[addr_index] <= victim_way;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
// two-way write-back data cache, processor word port and memory line port
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_top (
	input wire clk,
	input wire proc_reset,

	// processor port
	input wire proc_read,
	input wire proc_write,
	input wire logic [`DC_ADDR_W-1:0] proc_addr,
	input wire dcache_pkg::word_t proc_wdata,
	output dcache_pkg::word_t proc_rdata,
	output logic proc_stall,

	// memory port
	output logic mem_read,
	output logic mem_write,
	output dcache_pkg::line_addr_t mem_addr,
	output dcache_pkg::line_t mem_wdata,
	input wire dcache_pkg::line_t mem_rdata,
	input wire mem_ready
);

	// addressed set as read from the arrays
	dcache_pkg::tag_entry_t tag0;
	dcache_pkg::tag_entry_t tag1;
	dcache_pkg::line_t line0;
	dcache_pkg::line_t line1;

	// lookup results
	logic hit0;
	logic hit1;
	logic victim_way;
	logic victim_dirty;
	dcache_pkg::line_addr_t victim_addr;
	dcache_pkg::line_t victim_line;
	dcache_pkg::line_t merged_line;

	// array write controls
	logic [`DC_WAYS-1:0] tag_wr_en;
	logic [`DC_WAYS-1:0] data_wr_en;
	dcache_pkg::tag_entry_t wr_tag_entry;
	dcache_pkg::line_t wr_line;

	// ------------------------------
	// way arrays
	// ------------------------------
	dcache_way_array #(.entry_t(dcache_pkg::tag_entry_t)) i_tag_way0 (
		.clk      (clk),
		.proc_reset (proc_reset),
		.rd_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.rd_entry (tag0),
		.wr_en    (tag_wr_en[0]),
		.wr_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.wr_entry (wr_tag_entry)
	);

	dcache_way_array #(.entry_t(dcache_pkg::tag_entry_t)) i_tag_way1 (
		.clk      (clk),
		.proc_reset (proc_reset),
		.rd_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.rd_entry (tag1),
		.wr_en    (tag_wr_en[1]),
		.wr_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.wr_entry (wr_tag_entry)
	);

	dcache_way_array #(.entry_t(dcache_pkg::line_t)) i_data_way0 (
		.clk      (clk),
		.proc_reset (proc_reset),
		.rd_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.rd_entry (line0),
		.wr_en    (data_wr_en[0]),
		.wr_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.wr_entry (wr_line)
	);

	dcache_way_array #(.entry_t(dcache_pkg::line_t)) i_data_way1 (
		.clk      (clk),
		.proc_reset (proc_reset),
		.rd_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.rd_entry (line1),
		.wr_en    (data_wr_en[1]),
		.wr_index (proc_addr[`DC_OFFSET_W +: `DC_INDEX_W]),
		.wr_entry (wr_line)
	);

	// ------------------------------
	// lookup and control
	// ------------------------------
	dcache_lookup i_lookup (
		.proc_addr    (proc_addr),
		.proc_wdata   (proc_wdata),
		.tag0         (tag0),
		.tag1         (tag1),
		.line0        (line0),
		.line1        (line1),
		.victim_way   (victim_way),
		.hit0         (hit0),
		.hit1         (hit1),
		.rdata        (proc_rdata),
		.merged_line  (merged_line),
		.victim_dirty (victim_dirty),
		.victim_addr  (victim_addr),
		.victim_line  (victim_line)
	);

	dcache_ctrl i_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.proc_stall   (proc_stall),
		.hit0         (hit0),
		.hit1         (hit1),
		.victim_dirty (victim_dirty),
		.victim_addr  (victim_addr),
		.victim_line  (victim_line),
		.merged_line  (merged_line),
		.tag0         (tag0),
		.tag1         (tag1),
		.victim_way   (victim_way),
		.tag_wr_en    (tag_wr_en),
		.data_wr_en   (data_wr_en),
		.wr_tag_entry (wr_tag_entry),
		.wr_line      (wr_line),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready)
	);

endmodule

`default_nettype wire

// ==== verif/dcache_assertions.sv ====
// protocol checks on the cache processor and memory handshakes
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module dcache_assertions (
	input wire clk,
	input wire proc_reset,
	input wire proc_read,
	input wire proc_write,
	input wire logic [`DC_ADDR_W-1:0] proc_addr,
	input wire dcache_pkg::word_t proc_wdata,
	input wire proc_stall,
	input wire mem_read,
	input wire mem_write,
	input wire dcache_pkg::line_addr_t mem_addr,
	input wire dcache_pkg::line_t mem_wdata,
	input wire mem_ready
);

	// one memory transfer at a time
	strobes_exclusive: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high in the same cycle");

	// ------------------------------
	// memory side holds until ready
	// ------------------------------
	fill_held: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
		else $error("fill request changed before mem_ready");

	write_back_held: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_write && !mem_ready) |=>
			(mem_write && $stable(mem_addr) && $stable(mem_wdata)))
		else $error("write-back request changed before mem_ready");

	// stalled request must not move
	request_held: assert property (@(posedge clk) disable iff (proc_reset)
		((proc_read || proc_write) && proc_stall) |=>
			($stable(proc_read) && $stable(proc_write)
			&& $stable(proc_addr) && $stable(proc_wdata)))
		else $error("processor request changed while stalled");

endmodule

`default_nettype wire

// ==== verif/tb_dcache.sv ====
// trace-driven testbench for the data cache with a slow line memory model
`timescale 1ns/1ns
`default_nettype none

`include "dcache_params.svh"

module tb_dcache;

	localparam logic [31:0] MEM_PATTERN = 32'hA5A50000; // unwritten word = address ^ this
	localparam int MEM_LAT_MIN = 1;
	localparam int MEM_LAT_MAX = 4;
	localparam int CYCLES_PER_REQ = 40;

	logic clk;
	logic proc_reset;
	logic proc_read;
	logic proc_write;
	logic [`DC_ADDR_W-1:0] proc_addr;
	dcache_pkg::word_t proc_wdata;
	dcache_pkg::word_t proc_rdata;
	logic proc_stall;
	logic mem_read;
	logic mem_write;
	dcache_pkg::line_addr_t mem_addr;
	dcache_pkg::line_t mem_wdata;
	dcache_pkg::line_t mem_rdata;
	logic mem_ready;

	// trace columns
	byte op_q[$];
	logic [`DC_ADDR_W-1:0] addr_q[$];
	dcache_pkg::word_t wdata_q[$];
	dcache_pkg::word_t expect_q[$];
	int hit_q[$];
	int wb_q[$];

	dcache_pkg::line_t mem_lines [dcache_pkg::line_addr_t]; // written-back lines only
	int wb_count;
	int error_count;
	int test_count;
	int cycle_count;
	int cycle_limit;
	int unsigned delay;
	logic busy;

	dcache_top i_dcache_top (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	bind dcache_top dcache_assertions i_assertions (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_ready  (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// memory model
	// ------------------------------
	function automatic dcache_pkg::line_t read_line(input dcache_pkg::line_addr_t line_addr);
		dcache_pkg::line_t fill_line;
		logic [`DC_ADDR_W-1:0] word_addr;
		if (mem_lines.exists(line_addr)) begin
			return mem_lines[line_addr];
		end
		for (int w = 0; w < 4; w++) begin
			word_addr = {line_addr, w[1:0]};
			fill_line[w*`DC_WORD_W +: `DC_WORD_W] = {2'b00, word_addr} ^ MEM_PATTERN;
		end
		return fill_line;
	endfunction

	initial begin
		void'($urandom(66360)); // delay draws come from this process
		forever begin
			@(negedge clk);
			if (proc_reset) begin
				mem_ready = 1'b0;
				busy = 1'b0;
			end else if (mem_ready) begin
				mem_ready = 1'b0; // taken at the last edge
				busy = 1'b0;
			end else if (mem_read || mem_write) begin
				if (!busy) begin
					busy = 1'b1;
					delay = $urandom_range(MEM_LAT_MAX, MEM_LAT_MIN);
				end
				delay--;
				if (delay == 0) begin
					if (mem_write) begin
						mem_lines[mem_addr] = mem_wdata;
						wb_count++;
					end else begin
						mem_rdata = read_line(mem_addr);
					end
					mem_ready = 1'b1;
				end
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, a request never completed", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ------------------------------
	// trace and requests
	// ------------------------------
	task automatic load_trace();
		int fd;
		int rc;
		string text;
		byte op;
		logic [`DC_ADDR_W-1:0] addr;
		dcache_pkg::word_t wdata;
		dcache_pkg::word_t exp_data;
		int hit;
		int wb;
		fd = $fopen("verif/dcache_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file");
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(text, fd);
				if (rc > 0) begin
					rc = $sscanf(text, "%c %h %h %h %d %d", op, addr, wdata, exp_data, hit, wb);
					if (rc == 6) begin // comment lines fall out here
						op_q.push_back(op);
						addr_q.push_back(addr);
						wdata_q.push_back(wdata);
						expect_q.push_back(exp_data);
						hit_q.push_back(hit);
						wb_q.push_back(wb);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_request(input int idx);
		int stalls;
		int wb_before;
		int wb_seen;
		logic ok;
		stalls = 0;
		ok = 1'b1;
		wb_before = wb_count;
		@(negedge clk);
		proc_read = (op_q[idx] == "R");
		proc_write = (op_q[idx] == "W");
		proc_addr = addr_q[idx];
		proc_wdata = wdata_q[idx];
		@(posedge clk);
		while (proc_stall) begin
			stalls++;
			@(posedge clk);
		end
		wb_seen = wb_count - wb_before;
		if (proc_read && proc_rdata != expect_q[idx]) begin
			$display("FAILED proc_rdata: got %h, expected %h", proc_rdata, expect_q[idx]);
			ok = 1'b0;
		end
		if (hit_q[idx] != 0 && stalls != 0) begin
			$display("request stalled %0d cycles where a hit was expected", stalls);
			ok = 1'b0;
		end
		if (hit_q[idx] == 0 && stalls == 0) begin
			$display("request completed without the expected miss");
			ok = 1'b0;
		end
		if (wb_seen != wb_q[idx]) begin
			$display("FAILED mem_write count: got %h, expected %h", wb_seen, wb_q[idx]);
			ok = 1'b0;
		end
		test_count++;
		if (!ok) error_count++;
		$display("test %0d: %c %h %s", idx + 1, op_q[idx], addr_q[idx], ok ? "ok" : "error");
		@(negedge clk);
		proc_read = 1'b0;
		proc_write = 1'b0;
	endtask

	initial begin
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		mem_rdata = '0;
		mem_ready = 1'b0;
		busy = 1'b0;
		delay = 0;
		wb_count = 0;
		error_count = 0;
		test_count = 0;
		cycle_count = 0;
		cycle_limit = 0;

		load_trace();
		cycle_limit = op_q.size() * CYCLES_PER_REQ;
		if (op_q.size() == 0) begin
			$display("trace file holds no requests");
			error_count++;
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;

		// idle cache after reset
		@(posedge clk);
		test_count++;
		if (mem_read || mem_write || proc_stall) begin
			$display("FAILED idle outputs: mem_read %h mem_write %h proc_stall %h",
				mem_read, mem_write, proc_stall);
			error_count++;
		end
		$display("test 0: reset idle check done");

		for (int i = 0; i < op_q.size(); i++) begin
			run_request(i);
		end

		$display("tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/dcache_trace.txt ====
# op addr wdata expect hit wb : op R or W, hex word address, hex write data, hex read data
# hit 1 means no stall cycle, wb is the number of memory writes during the request
R 00000104 00000000 a5a50104 0 0
R 00000104 00000000 a5a50104 1 0
W 00000105 12345678 00000000 1 0
R 00000105 00000000 12345678 1 0
R 00000104 00000000 a5a50104 1 0
R 00000106 00000000 a5a50106 1 0
R 00000107 00000000 a5a50107 1 0
# three tags in set 2
R 00000408 00000000 a5a50408 0 0
R 00000508 00000000 a5a50508 0 0
R 00000408 00000000 a5a50408 1 0
R 00000608 00000000 a5a50608 0 0
R 00000508 00000000 a5a50508 1 0
R 00000408 00000000 a5a50408 0 0
R 00000608 00000000 a5a50608 1 0
R 00000508 00000000 a5a50508 0 0
# dirty victims in set 1
R 00000204 00000000 a5a50204 0 0
R 00000304 00000000 a5a50304 0 1
R 00000105 00000000 12345678 0 0
R 00000107 00000000 a5a50107 1 0
R 00000104 00000000 a5a50104 1 0
W 00000307 deadbeef 00000000 1 0
R 00000204 00000000 a5a50204 0 1
R 00000307 00000000 deadbeef 0 0
R 00000304 00000000 a5a50304 1 0
# write miss allocates
W 000000c1 cafef00d 00000000 0 0
R 000000c1 00000000 cafef00d 1 0
R 000000c0 00000000 a5a500c0 1 0

// ==== vlog.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_way_array.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/dcache_assertions.sv
verif/tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
